// ==== saturn_dec_pkg.sv ====
`default_nettype none

package saturn_dec_pkg;

  // one opcode or data nibble
  typedef logic [3:0] nibble_t;

  // program counter of 20 bits by architecture
  typedef logic [19:0] addr_t;

  // ALU operation code
  typedef logic [4:0] alu_op_t;

  // assembled immediate with nibble 0 in bits 3:0
  typedef logic [63:0] imm_t;

  // nibble count or write position up to 16
  typedef logic [4:0] imm_pos_t;

  // ALU operations used by the decoder
  localparam alu_op_t ALU_OP_ZERO     = 5'd0;
  localparam alu_op_t ALU_OP_COPY     = 5'd1;
  localparam alu_op_t ALU_OP_EXCH     = 5'd2;
  localparam alu_op_t ALU_OP_INC      = 5'd3;
  localparam alu_op_t ALU_OP_DEC      = 5'd4;

  // relative jumps with 2 or 3 offset nibbles
  localparam alu_op_t ALU_OP_JMP_REL2 = 5'd5;
  localparam alu_op_t ALU_OP_JMP_REL3 = 5'd6;

endpackage

`default_nettype wire

// ==== imm_collector.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_collector import saturn_dec_pkg::*; (
  input  wire      i_clk,
  input  wire      i_reset,
  input  wire      i_imm_start,
  input  imm_pos_t i_imm_count,
  input  wire      i_imm_take,
  input  nibble_t  i_nibble,
  output imm_t     o_mem_load,
  output imm_pos_t o_mem_pos,
  output logic     o_imm_last
);

  // number of nibbles expected for the current immediate
  imm_pos_t target_count;
  imm_pos_t next_pos;

  assign next_pos = o_mem_pos + 5'd1;

  // the nibble being taken now completes the immediate
  assign o_imm_last = (next_pos == target_count);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      target_count <= '0;
      o_mem_pos    <= '0;
      o_mem_load   <= '0;
    end else begin
      if (i_imm_start) begin
        // new immediate restarts from nibble 0
        target_count <= i_imm_count;
        o_mem_pos    <= '0;
        o_mem_load   <= '0;
      end else if (i_imm_take) begin
        // little-nibble-first placement
        o_mem_load[o_mem_pos[3:0]*4 +: 4] <= i_nibble;
        o_mem_pos                         <= next_pos;
      end
    end
  end

endmodule

`default_nettype wire

// ==== dec_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dec_sequencer import saturn_dec_pkg::*; (
  input  wire      i_clk,
  input  wire      i_reset,
  input  wire      i_en_dec,
  input  wire      i_stalled,
  input  addr_t    i_pc,
  input  nibble_t  i_nibble,
  input  wire      i_imm_last,

  // immediate collector control
  output logic     o_imm_start,
  output imm_pos_t o_imm_count,
  output logic     o_imm_take,

  // decoded instruction
  output addr_t    o_ins_addr,
  output logic     o_ins_decoded,
  output logic     o_dec_error,
  output alu_op_t  o_alu_op,
  output logic     o_ins_alu_op,
  output nibble_t  o_imm_value,

  // return and stack
  output logic     o_ins_rtn,
  output logic     o_push,
  output logic     o_pop,
  output logic     o_set_xm,
  output logic     o_en_intr,

  // carry handling
  output logic     o_set_carry,
  output logic     o_carry_val,
  output logic     o_test_carry,

  // hex / dec mode
  output logic     o_ins_set_mode,
  output logic     o_mode_dec
);

  typedef enum logic [2:0] {
    ST_FIRST,
    ST_BLOCK_0X,
    ST_BLOCK_2X,
    ST_BLOCK_3X,
    ST_COLLECT
  } dec_state_t;

  dec_state_t state;

  logic accept;
  logic first_acc;
  logic is_jump;

  // a nibble moves only when enabled and not stalled
  assign accept    = i_en_dec && !i_stalled;
  assign first_acc = accept && (state == ST_FIRST);

  // 4, 5, 6, 7 are the relative jumps
  assign is_jump   = (i_nibble[3:2] == 2'b01);

  assign o_imm_take  = accept && (state == ST_COLLECT);
  assign o_imm_start = (first_acc && is_jump) ||
                       (accept && (state == ST_BLOCK_3X));

  // 3n loads n+1 nibbles, 4/5 take 2 and 6/7 take 3
  always_comb begin
    if (state == ST_BLOCK_3X) begin
      o_imm_count = {1'b0, i_nibble} + 5'd1;
    end else if (i_nibble[1]) begin
      o_imm_count = 5'd3;
    end else begin
      o_imm_count = 5'd2;
    end
  end

  // instruction address and immediate nibble
  always_ff @(posedge i_clk) begin
    if (first_acc) begin
      o_ins_addr  <= i_pc;
      o_imm_value <= '0;
    end else if (accept && (state == ST_BLOCK_2X || state == ST_COLLECT)) begin
      o_imm_value <= i_nibble;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state          <= ST_FIRST;
      o_ins_decoded  <= 1'b0;
      o_dec_error    <= 1'b0;
      o_alu_op       <= ALU_OP_ZERO;
      o_ins_alu_op   <= 1'b0;
      o_ins_rtn      <= 1'b0;
      o_push         <= 1'b0;
      o_pop          <= 1'b0;
      o_set_xm       <= 1'b0;
      o_en_intr      <= 1'b0;
      o_set_carry    <= 1'b0;
      o_carry_val    <= 1'b0;
      o_test_carry   <= 1'b0;
      o_ins_set_mode <= 1'b0;
      o_mode_dec     <= 1'b0;
    end else begin
      // completion and error are single-cycle pulses
      o_ins_decoded <= 1'b0;
      o_dec_error   <= 1'b0;

      if (accept) begin
        case (state)
          ST_FIRST: begin
            // drop whatever the last instruction left behind
            o_alu_op       <= ALU_OP_ZERO;
            o_ins_alu_op   <= 1'b0;
            o_ins_rtn      <= 1'b0;
            o_push         <= 1'b0;
            o_pop          <= 1'b0;
            o_set_xm       <= 1'b0;
            o_en_intr      <= 1'b0;
            o_set_carry    <= 1'b0;
            o_carry_val    <= 1'b0;
            o_test_carry   <= 1'b0;
            o_ins_set_mode <= 1'b0;
            o_mode_dec     <= 1'b0;

            case (i_nibble)
              4'h0: state <= ST_BLOCK_0X;
              4'h2: state <= ST_BLOCK_2X;
              4'h3: state <= ST_BLOCK_3X;
              4'h4, 4'h5: begin
                // GOC / GONC jump when carry differs from nibble bit 0
                o_alu_op     <= ALU_OP_JMP_REL2;
                o_test_carry <= 1'b1;
                o_carry_val  <= !i_nibble[0];
                state        <= ST_COLLECT;
              end
              4'h6, 4'h7: begin
                // GOSUB also pushes the return address
                o_alu_op <= ALU_OP_JMP_REL3;
                o_push   <= i_nibble[0];
                state    <= ST_COLLECT;
              end
              default: o_dec_error <= 1'b1;
            endcase
          end

          ST_BLOCK_0X: begin
            case (i_nibble)
              4'h0, 4'h1, 4'h2, 4'h3, 4'hF: begin
                // RTNSXM, RTN, RTNSC, RTNCC, RTI
                o_ins_rtn   <= 1'b1;
                o_pop       <= 1'b1;
                o_set_xm    <= (i_nibble == 4'h0);
                o_set_carry <= !i_nibble[3] && i_nibble[1];
                o_carry_val <= !i_nibble[3] && i_nibble[1] && !i_nibble[0];
                o_en_intr   <= i_nibble[3];
              end
              4'h4, 4'h5: begin
                // SETHEX / SETDEC
                o_ins_set_mode <= 1'b1;
                o_mode_dec     <= i_nibble[0];
              end
              4'h6, 4'h7: begin
                // copies between return stack and C
                o_ins_alu_op <= 1'b1;
                o_alu_op     <= ALU_OP_COPY;
                o_push       <= !i_nibble[0];
                o_pop        <= i_nibble[0];
              end
              4'h8: begin
                o_ins_alu_op <= 1'b1;
                o_alu_op     <= ALU_OP_ZERO;
              end
              4'h9, 4'hA: begin
                o_ins_alu_op <= 1'b1;
                o_alu_op     <= ALU_OP_COPY;
              end
              4'hB: begin
                o_ins_alu_op <= 1'b1;
                o_alu_op     <= ALU_OP_EXCH;
              end
              4'hC, 4'hD: begin
                // P=P+1 / P=P-1
                o_ins_alu_op <= 1'b1;
                o_alu_op     <= i_nibble[0] ? ALU_OP_DEC : ALU_OP_INC;
              end
              default: begin
                // 0E is not supported here
                o_dec_error <= 1'b1;
              end
            endcase
            o_ins_decoded <= (i_nibble != 4'hE);
            state         <= ST_FIRST;
          end

          ST_BLOCK_2X: begin
            // P=n with the value on o_imm_value
            o_ins_alu_op  <= 1'b1;
            o_alu_op      <= ALU_OP_COPY;
            o_ins_decoded <= 1'b1;
            state         <= ST_FIRST;
          end

          ST_BLOCK_3X: begin
            // LC of n+1 nibbles through the collector
            o_ins_alu_op <= 1'b1;
            o_alu_op     <= ALU_OP_COPY;
            state        <= ST_COLLECT;
          end

          ST_COLLECT: begin
            o_ins_alu_op <= 1'b1;
            if (i_imm_last) begin
              o_ins_decoded <= 1'b1;
              state         <= ST_FIRST;
            end
          end

          default: state <= ST_FIRST;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== saturn_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module saturn_decoder import saturn_dec_pkg::*; (
  input  wire      i_clk,
  input  wire      i_reset,
  input  wire      i_en_dec,
  input  wire      i_stalled,
  input  addr_t    i_pc,
  input  nibble_t  i_nibble,

  output addr_t    o_ins_addr,
  output logic     o_ins_decoded,
  output logic     o_dec_error,
  output alu_op_t  o_alu_op,
  output logic     o_ins_alu_op,
  output nibble_t  o_imm_value,
  output imm_t     o_mem_load,
  output imm_pos_t o_mem_pos,
  output logic     o_ins_rtn,
  output logic     o_push,
  output logic     o_pop,
  output logic     o_set_xm,
  output logic     o_set_carry,
  output logic     o_carry_val,
  output logic     o_test_carry,
  output logic     o_en_intr,
  output logic     o_ins_set_mode,
  output logic     o_mode_dec
);

  // sequencer <-> collector handshake
  logic     imm_start;
  imm_pos_t imm_count;
  logic     imm_take;
  logic     imm_last;

  dec_sequencer u_sequencer (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_en_dec       (i_en_dec),
    .i_stalled      (i_stalled),
    .i_pc           (i_pc),
    .i_nibble       (i_nibble),
    .i_imm_last     (imm_last),
    .o_imm_start    (imm_start),
    .o_imm_count    (imm_count),
    .o_imm_take     (imm_take),
    .o_ins_addr     (o_ins_addr),
    .o_ins_decoded  (o_ins_decoded),
    .o_dec_error    (o_dec_error),
    .o_alu_op       (o_alu_op),
    .o_ins_alu_op   (o_ins_alu_op),
    .o_imm_value    (o_imm_value),
    .o_ins_rtn      (o_ins_rtn),
    .o_push         (o_push),
    .o_pop          (o_pop),
    .o_set_xm       (o_set_xm),
    .o_en_intr      (o_en_intr),
    .o_set_carry    (o_set_carry),
    .o_carry_val    (o_carry_val),
    .o_test_carry   (o_test_carry),
    .o_ins_set_mode (o_ins_set_mode),
    .o_mode_dec     (o_mode_dec)
  );

  // immediate and jump offset assembly
  imm_collector u_collector (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_imm_start (imm_start),
    .i_imm_count (imm_count),
    .i_imm_take  (imm_take),
    .i_nibble    (i_nibble),
    .o_mem_load  (o_mem_load),
    .o_mem_pos   (o_mem_pos),
    .o_imm_last  (imm_last)
  );

endmodule

`default_nettype wire

// ==== tb_dec_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dec_checker import saturn_dec_pkg::*; (
  input  wire      i_clk,
  input  wire      i_reset,
  input  addr_t    i_ins_addr,
  input  wire      i_ins_decoded,
  input  wire      i_dec_error,
  input  alu_op_t  i_alu_op,
  input  wire      i_ins_alu_op,
  input  nibble_t  i_imm_value,
  input  imm_t     i_mem_load,
  input  imm_pos_t i_mem_pos,
  input  wire      i_ins_rtn,
  input  wire      i_push,
  input  wire      i_pop,
  input  wire      i_set_xm,
  input  wire      i_set_carry,
  input  wire      i_carry_val,
  input  wire      i_test_carry,
  input  wire      i_en_intr,
  input  wire      i_ins_set_mode,
  input  wire      i_mode_dec
);

  localparam integer PULSE_TIMEOUT = 200;

  // flag bits rtn push pop set_xm set_carry carry_val test_carry en_intr set_mode mode_dec
  typedef struct packed {
    logic       is_err;
    addr_t      addr;
    alu_op_t    alu_op;
    logic       ins_alu;
    nibble_t    imm_val;
    logic       chk_mem;
    imm_t       mem_load;
    imm_pos_t   mem_pos;
    logic [9:0] flags;
    nibble_t    op;
    nibble_t    sub;
  } expect_t;

  expect_t exp_q[$];
  integer  error_count = 0;
  integer  pass_count = 0;
  integer  fail_count = 0;
  integer  checked_count = 0;
  integer  test_errs;

  task automatic push_expect(input logic is_err, input addr_t addr, input alu_op_t alu_op,
                             input logic ins_alu, input nibble_t imm_val, input logic chk_mem,
                             input imm_t mem_load, input imm_pos_t mem_pos,
                             input logic [9:0] flags, input nibble_t op, input nibble_t sub);
    exp_q.push_back({is_err, addr, alu_op, ins_alu, imm_val, chk_mem, mem_load, mem_pos,
                     flags, op, sub});
  endtask

  task automatic compare_field(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
    if (exp_v !== act_v) begin
      $display("Mismatch at %0t ns: %s expected %0h, actual %0h", $time, name, exp_v, act_v);
      test_errs++;
    end
  endtask

  task automatic tally_test(input string label);
    error_count += test_errs;
    if (test_errs == 0)
      pass_count++;
    else
      fail_count++;
    $display("%s: %s", label, (test_errs == 0) ? "pass" : "fail");
  endtask

  // control outputs sit at 0 once reset is released
  task automatic check_after_reset();
    integer cycles;
    cycles    = 0;
    test_errs = 0;
    while (i_reset !== 1'b0 && cycles < PULSE_TIMEOUT) begin
      @(negedge i_clk);
      cycles++;
    end
    if (i_reset !== 1'b0) begin
      $display("Error: reset was never released");
      test_errs++;
    end
    compare_field("o_ins_decoded", 0, i_ins_decoded);
    compare_field("o_dec_error", 0, i_dec_error);
    compare_field("o_ins_rtn", 0, i_ins_rtn);
    compare_field("o_push", 0, i_push);
    compare_field("o_pop", 0, i_pop);
    compare_field("o_ins_alu_op", 0, i_ins_alu_op);
    compare_field("o_ins_set_mode", 0, i_ins_set_mode);
    compare_field("o_test_carry", 0, i_test_carry);
    tally_test("test after reset");
  endtask

  // one sample per falling edge keeps back-to-back pulses apart
  task automatic wait_for_pulse();
    integer cycles;
    cycles = 0;
    @(negedge i_clk);
    while (i_ins_decoded !== 1'b1 && i_dec_error !== 1'b1) begin
      cycles++;
      if (cycles >= PULSE_TIMEOUT) begin
        $display("Timeout at %0t ns: no decode or error pulse for %0d cycles", $time, cycles);
        error_count++;
        if (exp_q.size() != 0) begin
          exp_q.delete(0);
          checked_count++;
          fail_count++;
        end
        cycles = 0;
      end
      @(negedge i_clk);
    end
  endtask

  task automatic check_result();
    expect_t e;
    if (exp_q.size() == 0) begin
      $display("Error at %0t ns: result pulse with no instruction outstanding", $time);
      error_count++;
    end else begin
      e         = exp_q.pop_front();
      test_errs = 0;
      compare_field("o_ins_decoded", !e.is_err, i_ins_decoded);
      compare_field("o_dec_error", e.is_err, i_dec_error);
      compare_field("o_ins_addr", e.addr, i_ins_addr);
      compare_field("o_alu_op", e.alu_op, i_alu_op);
      compare_field("o_ins_alu_op", e.ins_alu, i_ins_alu_op);
      compare_field("o_imm_value", e.imm_val, i_imm_value);
      compare_field("o_ins_rtn", e.flags[9], i_ins_rtn);
      compare_field("o_push", e.flags[8], i_push);
      compare_field("o_pop", e.flags[7], i_pop);
      compare_field("o_set_xm", e.flags[6], i_set_xm);
      compare_field("o_set_carry", e.flags[5], i_set_carry);
      compare_field("o_carry_val", e.flags[4], i_carry_val);
      compare_field("o_test_carry", e.flags[3], i_test_carry);
      compare_field("o_en_intr", e.flags[2], i_en_intr);
      compare_field("o_ins_set_mode", e.flags[1], i_ins_set_mode);
      compare_field("o_mode_dec", e.flags[0], i_mode_dec);
      if (e.chk_mem) begin
        compare_field("o_mem_load", e.mem_load, i_mem_load);
        compare_field("o_mem_pos", e.mem_pos, i_mem_pos);
      end
      checked_count++;
      tally_test($sformatf("test %0d opcode %h %h pc %h", checked_count, e.op, e.sub, e.addr));
    end
  endtask

  initial begin
    check_after_reset();
    forever begin
      wait_for_pulse();
      check_result();
    end
  end

endmodule

`default_nettype wire

// ==== tb_saturn_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_saturn_decoder import saturn_dec_pkg::*; ();

  localparam integer NUM_INSTR     = 300;
  localparam integer DRAIN_TIMEOUT = 300;

  logic    i_clk = 1'b0;
  logic    i_reset;
  logic    i_en_dec;
  logic    i_stalled;
  addr_t   i_pc;
  nibble_t i_nibble;

  addr_t    o_ins_addr;
  alu_op_t  o_alu_op;
  nibble_t  o_imm_value;
  imm_t     o_mem_load;
  imm_pos_t o_mem_pos;
  logic     o_ins_decoded, o_dec_error, o_ins_alu_op, o_ins_rtn, o_push, o_pop;
  logic     o_set_xm, o_set_carry, o_carry_val, o_test_carry, o_en_intr;
  logic     o_ins_set_mode, o_mode_dec;

  integer  seed;
  integer  sent_count;
  integer  drain_cycles;
  integer  n;
  integer  k;
  nibble_t nib_q[$];
  addr_t   ins_pc;

  // expected decode of the instruction being built
  logic     e_err, e_ins_alu, e_chk_mem;
  alu_op_t  e_alu;
  nibble_t  e_imm_val, e_op, e_sub;
  imm_t     e_mem_load;
  imm_pos_t e_mem_pos;
  logic     e_rtn, e_push, e_pop, e_set_xm, e_set_carry, e_carry_val;
  logic     e_test_carry, e_en_intr, e_set_mode, e_mode_dec;

  always #50 i_clk = ~i_clk;

  saturn_decoder UUT (.*);

  tb_dec_checker u_checker (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_ins_addr     (o_ins_addr),
    .i_ins_decoded  (o_ins_decoded),
    .i_dec_error    (o_dec_error),
    .i_alu_op       (o_alu_op),
    .i_ins_alu_op   (o_ins_alu_op),
    .i_imm_value    (o_imm_value),
    .i_mem_load     (o_mem_load),
    .i_mem_pos      (o_mem_pos),
    .i_ins_rtn      (o_ins_rtn),
    .i_push         (o_push),
    .i_pop          (o_pop),
    .i_set_xm       (o_set_xm),
    .i_set_carry    (o_set_carry),
    .i_carry_val    (o_carry_val),
    .i_test_carry   (o_test_carry),
    .i_en_intr      (o_en_intr),
    .i_ins_set_mode (o_ins_set_mode),
    .i_mode_dec     (o_mode_dec)
  );

  function automatic integer rand_below(input integer limit);
    rand_below = {$random(seed)} % limit;
  endfunction

  // a few held cycles with garbage on the bus before one accepting cycle
  task automatic send_nibble(input nibble_t nib, input addr_t pc);
    integer gaps;
    gaps = (rand_below(4) == 0) ? 1 + rand_below(3) : 0;
    repeat (gaps) begin
      i_en_dec  = (rand_below(2) == 1);
      i_stalled = i_en_dec ? 1'b1 : (rand_below(2) == 1);
      i_nibble  = nibble_t'(rand_below(16));
      i_pc      = addr_t'($random(seed));
      @(negedge i_clk);
    end
    i_en_dec  = 1'b1;
    i_stalled = 1'b0;
    i_nibble  = nib;
    i_pc      = pc;
    @(negedge i_clk);
  endtask

  // immediate or offset nibbles in order from the lowest
  task automatic add_data(input integer count);
    integer  i;
    nibble_t d;
    for (i = 0; i < count; i++) begin
      d = nibble_t'(rand_below(16));
      nib_q.push_back(d);
      e_mem_load[i*4 +: 4] = d;
      e_imm_val            = d;
    end
    e_chk_mem = 1'b1;
    e_mem_pos = imm_pos_t'(count);
  endtask

  task automatic model_block_0x();
    case (e_sub)
      4'h0, 4'h1, 4'h2, 4'h3, 4'hF: begin
        e_rtn       = 1'b1;
        e_pop       = 1'b1;
        e_set_xm    = (e_sub == 4'h0);
        e_set_carry = (e_sub == 4'h2 || e_sub == 4'h3);
        e_carry_val = (e_sub == 4'h2);
        e_en_intr   = (e_sub == 4'hF);
      end
      4'h4, 4'h5: begin
        e_set_mode = 1'b1;
        e_mode_dec = (e_sub == 4'h5);
      end
      default: begin
        // 06 to 0D are all ALU forms
        e_ins_alu = 1'b1;
        e_alu     = (e_sub == 4'h8) ? ALU_OP_ZERO :
                    (e_sub == 4'hB) ? ALU_OP_EXCH :
                    (e_sub == 4'hC) ? ALU_OP_INC  :
                    (e_sub == 4'hD) ? ALU_OP_DEC  : ALU_OP_COPY;
        e_push    = (e_sub == 4'h6);
        e_pop     = (e_sub == 4'h7);
      end
    endcase
  endtask

  task automatic build_instruction();
    integer kind;
    integer pick;
    nib_q.delete();
    {e_err, e_ins_alu, e_chk_mem, e_rtn, e_push, e_pop, e_set_xm, e_set_carry} = '0;
    {e_carry_val, e_test_carry, e_en_intr, e_set_mode, e_mode_dec} = '0;
    e_alu      = ALU_OP_ZERO;
    e_imm_val  = '0;
    e_mem_load = '0;
    e_mem_pos  = '0;
    e_sub      = '0;
    ins_pc     = addr_t'($random(seed));
    kind       = rand_below(10);
    if (kind == 0) begin
      // unsupported 0E, 1x or 8x..Fx
      e_err = 1'b1;
      pick  = rand_below(10);
      e_op  = (pick == 0) ? 4'h0 : (pick == 1) ? 4'h1 : nibble_t'(pick + 6);
      if (pick == 0)
        e_sub = 4'hE;
    end else if (kind <= 3) begin
      e_op  = 4'h0;
      pick  = rand_below(15);
      e_sub = (pick == 14) ? 4'hF : nibble_t'(pick);
      model_block_0x();
    end else if (kind <= 6) begin
      // P=n or LC with n+1 nibbles
      e_op      = (kind == 4) ? 4'h2 : 4'h3;
      e_sub     = nibble_t'(rand_below(16));
      e_alu     = ALU_OP_COPY;
      e_ins_alu = 1'b1;
      e_imm_val = e_sub;
    end else begin
      e_op         = nibble_t'(4 + rand_below(4));
      e_alu        = (e_op < 4'h6) ? ALU_OP_JMP_REL2 : ALU_OP_JMP_REL3;
      e_ins_alu    = 1'b1;
      e_test_carry = (e_op < 4'h6);
      e_carry_val  = (e_op == 4'h4);
      e_push       = (e_op == 4'h7);
    end
    nib_q.push_back(e_op);
    if (e_op == 4'h0 || e_op == 4'h2 || e_op == 4'h3)
      nib_q.push_back(e_sub);
    if (e_op == 4'h3)
      add_data(e_sub + 1);
    else if (e_op >= 4'h4 && e_op <= 4'h7)
      add_data((e_op < 4'h6) ? 2 : 3);
  endtask

  initial begin
    seed       = 32'h4875_1b88;
    sent_count = 0;
    i_reset    = 1'b1;
    i_en_dec   = 1'b0;
    i_stalled  = 1'b0;
    i_pc       = '0;
    i_nibble   = '0;
    repeat (5) @(negedge i_clk);
    i_reset = 1'b0;
    // idle so the checker samples the post-reset state
    repeat (2) @(negedge i_clk);

    for (n = 0; n < NUM_INSTR; n++) begin
      build_instruction();
      u_checker.push_expect(e_err, ins_pc, e_alu, e_ins_alu, e_imm_val, e_chk_mem, e_mem_load,
                            e_mem_pos, {e_rtn, e_push, e_pop, e_set_xm, e_set_carry,
                            e_carry_val, e_test_carry, e_en_intr, e_set_mode, e_mode_dec},
                            e_op, e_sub);
      sent_count++;
      send_nibble(nib_q[0], ins_pc);
      // pc is only meaningful with the first nibble
      for (k = 1; k < nib_q.size(); k++)
        send_nibble(nib_q[k], addr_t'($random(seed)));
    end
    i_en_dec = 1'b0;

    drain_cycles = 0;
    while (u_checker.checked_count < sent_count && drain_cycles < DRAIN_TIMEOUT) begin
      @(negedge i_clk);
      drain_cycles++;
    end
    // quiet cycles expose any extra result pulse
    repeat (4) @(negedge i_clk);
    if (u_checker.checked_count != sent_count)
      $display("Timeout: %0d of %0d instructions produced a result pulse",
               u_checker.checked_count, sent_count);
    $display("Counts: %0d tests passed, %0d tests failed, %0d errors",
             u_checker.pass_count, u_checker.fail_count, u_checker.error_count);
    if (u_checker.checked_count == sent_count && u_checker.error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== saturn_nibble_decoder.f ====
saturn_dec_pkg.sv
imm_collector.sv
dec_sequencer.sv
saturn_decoder.sv
tb_dec_checker.sv
tb_saturn_decoder.sv
